// File: hw/UsiDefines_defines.svh
/* USI bus widths and address map */
`ifndef USI_DEFINES_SVH
`define USI_DEFINES_SVH

//----------------------------------------
// Bus widths
//----------------------------------------
`define USI_DATA_BIT        32
`define USI_ADRS_BIT        16
// Upper address byte picks the block, lower byte the register
`define USI_MAP_BIT         8
`define USI_REG_BIT         8

//----------------------------------------
// Block address map
//----------------------------------------
`define USI_GPIO_MAP        8'h01
`define USI_PWM_MAP         8'h02

// GPIO registers
`define USI_GPIO_OUT_REG    8'h00
`define USI_GPIO_IN_REG     8'h04

// PWM registers, count is read only
`define USI_PWM_CTRL_REG    8'h00
`define USI_PWM_PERIOD_REG  8'h04
`define USI_PWM_DUTY_REG    8'h08
`define USI_PWM_COUNT_REG   8'h0C
`define USI_PWM_EN_BIT      0
`define USI_PWM_CNT_BIT     16

`endif

// File: hw/UsiPkg.sv
/* USI bus types */
package UsiPkg;

	//----------------------------------------
	// Host command opcode
	//----------------------------------------
	typedef enum logic
	{
		UsiOpWrite = 1'b0,
		UsiOpRead  = 1'b1
	} UsiOpE;

	//----------------------------------------
	// Master FSM states
	//----------------------------------------
	// Write lasts two cycles inside UsiWrite
	// Read goes request then wait for rEd
	typedef enum logic [1:0]
	{
		UsiIdle     = 2'd0,
		UsiWrite    = 2'd1,
		UsiReadReq  = 2'd2,
		UsiReadWait = 2'd3
	} UsiStateE;

endpackage

// File: hw/UsiBusIf.sv
/* USI bus interface */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

interface UsiBusIf;

	// Request side
	logic [`USI_DATA_BIT-1:0] wd;
	logic [`USI_ADRS_BIT-1:0] adrs;
	// One-cycle strobes
	logic                     wCke;
	logic                     rCke;
	// Return side
	logic [`USI_DATA_BIT-1:0] rd;
	logic                     rEd;

	// Request driver, also used by the fabric toward each slave
	modport master
	(
		output wd, adrs, wCke, rCke,
		input  rd, rEd
	);

	// Fabric port facing the master
	modport fabric
	(
		input  wd, adrs, wCke, rCke,
		output rd, rEd
	);

	// Peripheral block
	modport slave
	(
		input  wd, adrs, wCke, rCke,
		output rd, rEd
	);

endinterface

// File: hw/PwmTimer.sv
/* PWM period counter */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module PwmTimer
(
	input  logic                        sysClk,
	input  logic                        rstN,
	input  logic                        enable,
	input  logic [`USI_PWM_CNT_BIT-1:0] period,
	output logic [`USI_PWM_CNT_BIT-1:0] count
);

logic stopped;
logic atEnd;

// Held at zero while off or with no period
assign stopped = !enable || (period == '0);
// Also catches a period shrunk below the count
assign atEnd   = (count >= period - 1'b1);

//----------------------------------------
// Counter
//----------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		count <= '0;
	end
	else if (stopped)
	begin
		count <= '0;
	end
	else if (atEnd)
	begin
		count <= '0;
	end
	else
	begin
		count <= count + 1'b1;
	end
end

// Count settles in range one cycle after a period change
assert property (@(posedge sysClk) disable iff (!rstN)
	($stable(period) && period != '0) |-> count < period)
	else $error("PwmTimer: count %0d not below period %0d", count, period);

endmodule

// File: hw/UsiMaster.sv
/* USI bus master */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module UsiMaster
	import UsiPkg::*;
(
	input  logic                     sysClk,
	input  logic                     rstN,
	input  logic                     cmdStrobe,
	input  UsiOpE                    cmdOp,
	input  logic [`USI_ADRS_BIT-1:0] cmdAdrs,
	input  logic [`USI_DATA_BIT-1:0] cmdWd,
	output logic                     busy,
	output logic                     rspValid,
	output logic [`USI_DATA_BIT-1:0] rspData,
	UsiBusIf.master                  bus
);

UsiStateE                 state;
logic                     qWCke;
logic                     qRCke;
logic [`USI_ADRS_BIT-1:0] qAdrs;
logic [`USI_DATA_BIT-1:0] qWd;
logic                     accept;
logic                     rspTake;

// Command taken only from idle
assign accept  = (state == UsiIdle) && cmdStrobe;
// Read data returns while waiting
assign rspTake = (state == UsiReadWait) && bus.rEd;
assign busy    = (state != UsiIdle);

//----------------------------------------
// Command FSM
//----------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		state    <= UsiIdle;
		qWCke    <= 1'b0;
		qRCke    <= 1'b0;
		rspValid <= 1'b0;
	end
	else
	begin
		rspValid <= 1'b0;
		case (state)
			UsiIdle:
			begin
				if (accept && cmdOp == UsiOpWrite)
				begin
					state <= UsiWrite;
					qWCke <= 1'b1;
				end
				else if (accept)
				begin
					state <= UsiReadReq;
					qRCke <= 1'b1;
				end
			end
			// First cycle strobes, second covers the fabric stage
			UsiWrite:
			begin
				if (qWCke)
					qWCke <= 1'b0;
				else
					state <= UsiIdle;
			end
			UsiReadReq:
			begin
				qRCke <= 1'b0;
				state <= UsiReadWait;
			end
			UsiReadWait:
			begin
				if (rspTake)
				begin
					rspValid <= 1'b1;
					state    <= UsiIdle;
				end
			end
			default:
			begin
				state <= UsiIdle;
			end
		endcase
	end
end

// Latched command and captured response
always_ff @(posedge sysClk)
begin
	if (accept)
	begin
		qAdrs <= cmdAdrs;
		qWd   <= cmdWd;
	end
	if (rspTake)
		rspData <= bus.rd;
end

assign bus.wd   = qWd;
assign bus.adrs = qAdrs;
assign bus.wCke = qWCke;
assign bus.rCke = qRCke;

//----------------------------------------
// Protocol checks
//----------------------------------------
// Host has no back-pressure, it must honour busy
assert property (@(posedge sysClk) disable iff (!rstN) cmdStrobe |-> !busy)
	else $error("UsiMaster: cmdStrobe while busy");

// Any slave answer outside the wait state is a stray response
assert property (@(posedge sysClk) disable iff (!rstN) bus.rEd |-> state == UsiReadWait)
	else $error("UsiMaster: rEd outside UsiReadWait");

assert property (@(posedge sysClk) disable iff (!rstN) !(bus.wCke && bus.rCke))
	else $error("UsiMaster: wCke and rCke together");

endmodule

// File: hw/UsiInterconnect.sv
/* USI address decode and return mux */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module UsiInterconnect
(
	input  logic    sysClk,
	input  logic    rstN,
	UsiBusIf.fabric mst,
	UsiBusIf.master gpio,
	UsiBusIf.master pwm
);

logic [`USI_MAP_BIT-1:0]  blockSel;
logic                     gpioHit;
logic                     pwmHit;
logic [`USI_DATA_BIT-1:0] qWd;
logic [`USI_ADRS_BIT-1:0] qAdrs;
logic                     qGpioWCke;
logic                     qGpioRCke;
logic                     qPwmWCke;
logic                     qPwmRCke;
logic                     qNoHitRCke;
logic                     qNoHitREd;

//----------------------------------------
// Block decode
//----------------------------------------
assign blockSel = mst.adrs[`USI_ADRS_BIT-1 -: `USI_MAP_BIT];
assign gpioHit  = (blockSel == `USI_GPIO_MAP);
assign pwmHit   = (blockSel == `USI_PWM_MAP);

// One register stage toward the slaves
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		qGpioWCke  <= 1'b0;
		qGpioRCke  <= 1'b0;
		qPwmWCke   <= 1'b0;
		qPwmRCke   <= 1'b0;
		qNoHitRCke <= 1'b0;
		qNoHitREd  <= 1'b0;
	end
	else
	begin
		qGpioWCke  <= mst.wCke & gpioHit;
		qGpioRCke  <= mst.rCke & gpioHit;
		qPwmWCke   <= mst.wCke & pwmHit;
		qPwmRCke   <= mst.rCke & pwmHit;
		// Unmapped read answers like a slave would
		qNoHitRCke <= mst.rCke & ~(gpioHit | pwmHit);
		qNoHitREd  <= qNoHitRCke;
	end
end

// Broadcast payload
always_ff @(posedge sysClk)
begin
	qWd   <= mst.wd;
	qAdrs <= mst.adrs;
end

assign gpio.wd   = qWd;
assign gpio.adrs = qAdrs;
assign gpio.wCke = qGpioWCke;
assign gpio.rCke = qGpioRCke;
assign pwm.wd    = qWd;
assign pwm.adrs  = qAdrs;
assign pwm.wCke  = qPwmWCke;
assign pwm.rCke  = qPwmRCke;

//----------------------------------------
// Read return
//----------------------------------------
// Unmapped answer carries zero data
assign mst.rEd = gpio.rEd | pwm.rEd | qNoHitREd;
assign mst.rd  = gpio.rEd ? gpio.rd : (pwm.rEd ? pwm.rd : '0);

// Slaves must never answer in the same cycle
assert property (@(posedge sysClk) disable iff (!rstN) !(gpio.rEd && pwm.rEd))
	else $error("UsiInterconnect: both slaves raised rEd");

endmodule

// File: hw/GpioBlock.sv
/* GPIO slave */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module GpioBlock #(
	parameter int pGpioWidth = 8
)(
	input  logic                  sysClk,
	input  logic                  rstN,
	UsiBusIf.slave                bus,
	input  logic [pGpioWidth-1:0] gpioIn,
	output logic [pGpioWidth-1:0] gpioOut
);

logic [`USI_REG_BIT-1:0]  regAdrs;
logic [pGpioWidth-1:0]    qSyncA;
logic [pGpioWidth-1:0]    qSyncB;
logic [`USI_DATA_BIT-1:0] outExt;
logic [`USI_DATA_BIT-1:0] inExt;
logic [`USI_DATA_BIT-1:0] qRd;
logic                     qREd;

assign regAdrs = bus.adrs[`USI_REG_BIT-1:0];

// Zero-extend to bus width
always_comb
begin
	outExt                 = '0;
	inExt                  = '0;
	outExt[pGpioWidth-1:0] = gpioOut;
	inExt[pGpioWidth-1:0]  = qSyncB;
end

// Output register, input synchronizer, read strobe
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		gpioOut <= '0;
		qSyncA  <= '0;
		qSyncB  <= '0;
		qREd    <= 1'b0;
	end
	else
	begin
		if (bus.wCke && regAdrs == `USI_GPIO_OUT_REG)
			gpioOut <= bus.wd[pGpioWidth-1:0];
		qSyncA <= gpioIn;
		qSyncB <= qSyncA;
		qREd   <= bus.rCke;
	end
end

// Read data, unknown offset reads zero
always_ff @(posedge sysClk)
begin
	if (bus.rCke)
	begin
		case (regAdrs)
			`USI_GPIO_OUT_REG: qRd <= outExt;
			`USI_GPIO_IN_REG:  qRd <= inExt;
			default:           qRd <= '0;
		endcase
	end
end

assign bus.rd  = qRd;
assign bus.rEd = qREd;

endmodule

// File: hw/PwmBlock.sv
/* PWM backlight slave */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module PwmBlock
(
	input  logic   sysClk,
	input  logic   rstN,
	UsiBusIf.slave bus,
	output logic   backLight
);

localparam int lpPadBit = `USI_DATA_BIT - `USI_PWM_CNT_BIT;

logic [`USI_REG_BIT-1:0]     regAdrs;
logic                        qEnable;
logic [`USI_PWM_CNT_BIT-1:0] qPeriod;
logic [`USI_PWM_CNT_BIT-1:0] qDuty;
logic [`USI_PWM_CNT_BIT-1:0] count;
logic [`USI_DATA_BIT-1:0]    qRd;
logic                        qREd;
logic                        pwmOn;

assign regAdrs = bus.adrs[`USI_REG_BIT-1:0];

//----------------------------------------
// Period counter
//----------------------------------------
PwmTimer i_PwmTimer
(
	.sysClk (sysClk),
	.rstN   (rstN),
	.enable (qEnable),
	.period (qPeriod),
	.count  (count)
);

// Duty at or above period keeps it high
assign pwmOn = qEnable && (qPeriod != '0) && (count < qDuty);

// Config registers and backlight output
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		qEnable   <= 1'b0;
		qPeriod   <= '0;
		qDuty     <= '0;
		qREd      <= 1'b0;
		backLight <= 1'b0;
	end
	else
	begin
		if (bus.wCke)
		begin
			// Count register ignores writes
			case (regAdrs)
				`USI_PWM_CTRL_REG:   qEnable <= bus.wd[`USI_PWM_EN_BIT];
				`USI_PWM_PERIOD_REG: qPeriod <= bus.wd[`USI_PWM_CNT_BIT-1:0];
				`USI_PWM_DUTY_REG:   qDuty   <= bus.wd[`USI_PWM_CNT_BIT-1:0];
				default:             qEnable <= qEnable;
			endcase
		end
		qREd      <= bus.rCke;
		backLight <= pwmOn;
	end
end

// Readback, live count included
always_ff @(posedge sysClk)
begin
	if (bus.rCke)
	begin
		case (regAdrs)
			`USI_PWM_CTRL_REG:   qRd <= {{(`USI_DATA_BIT-1){1'b0}}, qEnable};
			`USI_PWM_PERIOD_REG: qRd <= {{lpPadBit{1'b0}}, qPeriod};
			`USI_PWM_DUTY_REG:   qRd <= {{lpPadBit{1'b0}}, qDuty};
			`USI_PWM_COUNT_REG:  qRd <= {{lpPadBit{1'b0}}, count};
			default:             qRd <= '0;
		endcase
	end
end

assign bus.rd  = qRd;
assign bus.rEd = qREd;

endmodule

// File: hw/Processer.sv
/* System management top */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module Processer
	import UsiPkg::*;
#(
	parameter int pGpioWidth = 8
)(
	input  logic                     sysClk,
	input  logic                     rstN,
	// Host command port
	input  logic                     cmdStrobe,
	input  UsiOpE                    cmdOp,
	input  logic [`USI_ADRS_BIT-1:0] cmdAdrs,
	input  logic [`USI_DATA_BIT-1:0] cmdWd,
	output logic                     busy,
	output logic                     rspValid,
	output logic [`USI_DATA_BIT-1:0] rspData,
	// Peripheral pins
	input  logic [pGpioWidth-1:0]    gpioIn,
	output logic [pGpioWidth-1:0]    gpioOut,
	output logic                     backLight
);

// Master side and one bus per slave
UsiBusIf mstBus ();
UsiBusIf gpioBus ();
UsiBusIf pwmBus ();

//----------------------------------------
// Bus master
//----------------------------------------
UsiMaster i_UsiMaster
(
	.sysClk    (sysClk),
	.rstN      (rstN),
	.cmdStrobe (cmdStrobe),
	.cmdOp     (cmdOp),
	.cmdAdrs   (cmdAdrs),
	.cmdWd     (cmdWd),
	.busy      (busy),
	.rspValid  (rspValid),
	.rspData   (rspData),
	.bus       (mstBus.master)
);

UsiInterconnect i_UsiInterconnect
(
	.sysClk (sysClk),
	.rstN   (rstN),
	.mst    (mstBus.fabric),
	.gpio   (gpioBus.master),
	.pwm    (pwmBus.master)
);

//----------------------------------------
// Slaves
//----------------------------------------
GpioBlock #(
	.pGpioWidth (pGpioWidth)
) i_GpioBlock (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.bus     (gpioBus.slave),
	.gpioIn  (gpioIn),
	.gpioOut (gpioOut)
);

PwmBlock i_PwmBlock
(
	.sysClk    (sysClk),
	.rstN      (rstN),
	.bus       (pwmBus.slave),
	.backLight (backLight)
);

endmodule

// File: verif/ProcesserTb.sv
/* Processer testbench */
`timescale 1ns/1ps
`include "UsiDefines_defines.svh"

module ProcesserTb
	import UsiPkg::*;
();

localparam int lpGpioWidth = 8;
localparam int lpMaxCycles = 6000;
localparam logic [`USI_ADRS_BIT-1:0] lpGpioOutAdrs   = {`USI_GPIO_MAP, `USI_GPIO_OUT_REG};
localparam logic [`USI_ADRS_BIT-1:0] lpGpioInAdrs    = {`USI_GPIO_MAP, `USI_GPIO_IN_REG};
localparam logic [`USI_ADRS_BIT-1:0] lpPwmCtrlAdrs   = {`USI_PWM_MAP, `USI_PWM_CTRL_REG};
localparam logic [`USI_ADRS_BIT-1:0] lpPwmPeriodAdrs = {`USI_PWM_MAP, `USI_PWM_PERIOD_REG};
localparam logic [`USI_ADRS_BIT-1:0] lpPwmDutyAdrs   = {`USI_PWM_MAP, `USI_PWM_DUTY_REG};
localparam logic [`USI_ADRS_BIT-1:0] lpPwmCountAdrs  = {`USI_PWM_MAP, `USI_PWM_COUNT_REG};
// Block code 8'h05 has no slave
localparam logic [`USI_ADRS_BIT-1:0] lpUnmapAdrs     = 16'h0500;

logic                     sysClk;
logic                     rstN;
logic                     cmdStrobe;
UsiOpE                    cmdOp;
logic [`USI_ADRS_BIT-1:0] cmdAdrs;
logic [`USI_DATA_BIT-1:0] cmdWd;
logic                     busy;
logic                     rspValid;
logic [`USI_DATA_BIT-1:0] rspData;
logic [lpGpioWidth-1:0]   gpioIn;
logic [lpGpioWidth-1:0]   gpioOut;
logic                     backLight;

// Checker state
int                       errCount = 0;
int                       cycleCount = 0;
string                    testName;
logic                     postReset;
logic [lpGpioWidth-1:0]   gpioModel;
logic [`USI_DATA_BIT-1:0] expData;
logic                     checkLimit;
logic                     windowOn;
logic                     offCheck;
int                       expDuty;
logic [63:0]              winMask;
logic [63:0]              blHist;
int                       seedVal;

Processer #(
	.pGpioWidth (lpGpioWidth)
) i_Processer (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.cmdStrobe (cmdStrobe),
	.cmdOp     (cmdOp),
	.cmdAdrs   (cmdAdrs),
	.cmdWd     (cmdWd),
	.busy      (busy),
	.rspValid  (rspValid),
	.rspData   (rspData),
	.gpioIn    (gpioIn),
	.gpioOut   (gpioOut),
	.backLight (backLight)
);

initial
begin
	sysClk = 1'b0;
	forever #5 sysClk = ~sysClk;
end

// Run limit and backlight history with the newest sample in bit 0
always @(posedge sysClk)
begin
	cycleCount <= cycleCount + 1;
	blHist     <= {blHist[62:0], backLight};
	if (cycleCount >= lpMaxCycles)
	begin
		$display("Timeout: run did not finish within %0d cycles", lpMaxCycles);
		$display("Errors: %0d", errCount);
		$display("tests failed");
		$finish;
	end
end

//----------------------------------------
// Checks
//----------------------------------------
assert property (@(posedge sysClk) (!rstN || postReset) |->
	(!busy && !rspValid && !backLight && gpioOut == '0))
else
begin
	errCount++;
	$display("[ERROR] %s: expected 0, actual busy %0b rspValid %0b backLight %0b gpioOut %0h",
		testName, $sampled(busy), $sampled(rspValid), $sampled(backLight), $sampled(gpioOut));
end

// Strobe sampled at edge 0 and response produced at edge 3
assert property (@(posedge sysClk) disable iff (!rstN)
	(cmdStrobe && cmdOp == UsiOpRead) |=> !rspValid ##1 !rspValid ##1 !rspValid ##1 rspValid)
else
begin
	errCount++;
	$display("%s: rspValid did not arrive 3 cycles after the read strobe", testName);
end

// Busy until the register update at edge 2
assert property (@(posedge sysClk) disable iff (!rstN)
	(cmdStrobe && cmdOp == UsiOpWrite) |=> busy ##1 busy ##1 !busy)
else
begin
	errCount++;
	$display("%s: busy did not span exactly two cycles of the write", testName);
end

assert property (@(posedge sysClk) disable iff (!rstN)
	(rspValid && !checkLimit) |-> rspData == expData)
else
begin
	errCount++;
	$display("[ERROR] %s: expected %0h, actual %0h", testName, $sampled(expData),
		$sampled(rspData));
end

// Live counter only has an upper bound
assert property (@(posedge sysClk) disable iff (!rstN)
	(rspValid && checkLimit) |-> rspData < expData)
else
begin
	errCount++;
	$display("[ERROR] %s: expected below %0d, actual %0d", testName, $sampled(expData),
		$sampled(rspData));
end

assert property (@(posedge sysClk) disable iff (!rstN) gpioOut == gpioModel)
else
begin
	errCount++;
	$display("[ERROR] %s: expected gpioOut %0h, actual %0h", testName, $sampled(gpioModel),
		$sampled(gpioOut));
end

// High cycles in the last P samples
assert property (@(posedge sysClk) disable iff (!rstN)
	windowOn |-> $countones(blHist & winMask) == expDuty)
else
begin
	errCount++;
	$display("[ERROR] %s: expected %0d high cycles, actual %0d", testName, $sampled(expDuty),
		$countones($sampled(blHist & winMask)));
end

assert property (@(posedge sysClk) disable iff (!rstN) offCheck |-> !backLight)
else
begin
	errCount++;
	$display("[ERROR] %s: expected backLight 0, actual %0b", testName, $sampled(backLight));
end

//----------------------------------------
// Stimulus tasks
//----------------------------------------
task automatic waitBusyLow();
	int waitCycles;
	waitCycles = 0;
	while (busy && waitCycles < 20)
	begin
		@(posedge sysClk);
		#1;
		waitCycles++;
	end
	if (busy)
	begin
		errCount++;
		$display("%s: busy stayed high after the command", testName);
	end
endtask

// Called 1 ns after an edge and returns likewise
task automatic busWrite(input logic [`USI_ADRS_BIT-1:0] adrs, input logic [31:0] data);
	cmdStrobe = 1'b1;
	cmdOp     = UsiOpWrite;
	cmdAdrs   = adrs;
	cmdWd     = data;
	@(posedge sysClk);
	#1;
	cmdStrobe = 1'b0;
	waitBusyLow();
	// Busy falls with edge 2 as the output register takes the value
	if (adrs == lpGpioOutAdrs)
		gpioModel = data[lpGpioWidth-1:0];
endtask

task automatic busRead(input logic [`USI_ADRS_BIT-1:0] adrs, input logic [31:0] expValue,
	input logic useLimit);
	expData    = expValue;
	checkLimit = useLimit;
	cmdStrobe  = 1'b1;
	cmdOp      = UsiOpRead;
	cmdAdrs    = adrs;
	cmdWd      = '0;
	@(posedge sysClk);
	#1;
	cmdStrobe = 1'b0;
	waitBusyLow();
	// Response sampled on the following edge
	@(posedge sysClk);
	#1;
endtask

task automatic checkWindow(input int period, input int duty);
	expDuty = duty;
	winMask = (64'd1 << period) - 64'd1;
	// Two periods of settling first
	repeat (2 * period) @(posedge sysClk);
	#1;
	windowOn = 1'b1;
	repeat (3 * period) @(posedge sysClk);
	#1;
	windowOn = 1'b0;
endtask

task automatic checkOff(input int cycles);
	repeat (2) @(posedge sysClk);
	#1;
	offCheck = 1'b1;
	repeat (cycles) @(posedge sysClk);
	#1;
	busRead(lpPwmCountAdrs, '0, 1'b0);
	offCheck = 1'b0;
endtask

//----------------------------------------
// Test sequence
//----------------------------------------
initial
begin
	int period;
	int duty;
	cmdStrobe  = 1'b0;
	cmdOp      = UsiOpWrite;
	cmdAdrs    = '0;
	cmdWd      = '0;
	gpioIn     = '0;
	rstN       = 1'b0;
	postReset  = 1'b0;
	gpioModel  = '0;
	expData    = '0;
	checkLimit = 1'b0;
	windowOn   = 1'b0;
	offCheck   = 1'b0;
	expDuty    = 0;
	winMask    = '0;
	blHist     = '0;
	testName   = "reset";
	seedVal    = $urandom(16);

	repeat (16) @(posedge sysClk);
	#1;
	rstN      = 1'b1;
	postReset = 1'b1;
	@(posedge sysClk);
	#1;
	postReset = 1'b0;

	testName = "gpio output";
	repeat (6)
	begin
		busWrite(lpGpioOutAdrs, $urandom);
		busRead(lpGpioOutAdrs, 32'(gpioModel), 1'b0);
	end

	testName = "gpio input";
	repeat (4)
	begin
		gpioIn = $urandom;
		repeat (4) @(posedge sysClk);
		#1;
		busRead(lpGpioInAdrs, 32'(gpioIn), 1'b0);
	end

	testName = "pwm duty";
	repeat (4)
	begin
		period = 2 + ($urandom % 63);
		duty   = $urandom % period;
		busWrite(lpPwmPeriodAdrs, period);
		busWrite(lpPwmDutyAdrs, duty);
		busWrite(lpPwmCtrlAdrs, 32'h1);
		checkWindow(period, duty);
		busRead(lpPwmCountAdrs, period, 1'b1);
		busWrite(lpPwmCtrlAdrs, 32'h0);
	end

	// Duty at or above period keeps the output high
	testName = "pwm full duty";
	period   = 2 + ($urandom % 63);
	duty     = period + ($urandom % 8);
	busWrite(lpPwmPeriodAdrs, period);
	busWrite(lpPwmDutyAdrs, duty);
	busWrite(lpPwmCtrlAdrs, 32'h1);
	checkWindow(period, period);

	testName = "pwm disabled";
	busWrite(lpPwmCtrlAdrs, 32'h0);
	checkOff(period);

	testName = "pwm zero period";
	busWrite(lpPwmCtrlAdrs, 32'h1);
	busWrite(lpPwmPeriodAdrs, 32'h0);
	checkOff(8);

	// Writes into the hole must not reach any slave
	// Offset 0 gets a cleared enable bit so a leak into the control register shows
	testName = "unmapped";
	busWrite(lpPwmPeriodAdrs, 32'h30);
	busRead(lpUnmapAdrs, '0, 1'b0);
	busWrite(lpUnmapAdrs, 32'hFFFF_FFFE);
	busWrite(lpUnmapAdrs | 16'h0004, 32'hFFFF_FFFF);
	busWrite(lpUnmapAdrs | 16'h0008, 32'hFFFF_FFFF);
	busRead(lpGpioOutAdrs, 32'(gpioModel), 1'b0);
	busRead(lpPwmCtrlAdrs, 32'h1, 1'b0);
	busRead(lpPwmPeriodAdrs, 32'h30, 1'b0);
	busRead(lpPwmDutyAdrs, duty, 1'b0);

	repeat (4) @(posedge sysClk);
	$display("Errors: %0d", errCount);
	if (errCount == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

endmodule

// File: src.f
+incdir+hw
hw/UsiPkg.sv
hw/UsiBusIf.sv
hw/PwmTimer.sv
hw/UsiMaster.sv
hw/UsiInterconnect.sv
hw/GpioBlock.sv
hw/PwmBlock.sv
hw/Processer.sv
verif/ProcesserTb.sv

// File: Bender.yml
package:
  name: processer

sources:
  - include_dirs:
      - hw
    files:
      - hw/UsiPkg.sv
      - hw/UsiBusIf.sv
      - hw/PwmTimer.sv
      - hw/UsiMaster.sv
      - hw/UsiInterconnect.sv
      - hw/GpioBlock.sv
      - hw/PwmBlock.sv
      - hw/Processer.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/ProcesserTb.sv
